// ==== common/car_pkg.sv ====
`default_nettype none

package car_pkg;

    // driving states, codes as used on the car
    typedef enum logic [1:0] {
        stop        = 2'b00,
        turn_right  = 2'b01,
        turn_left   = 2'b10,
        go_straight = 2'b11
    } drive_state_t;

    // all-dark run length before go straight gives up
    localparam logic [29:0] long_dark_cycles = 30'd20_000_000;

    // stable cycles before a sensor change is accepted
    localparam logic [15:0] debounce_cycles = 16'd1000;

    // display scan divider width
    localparam int scan_div_bits = 16;

    // pwm counter width, one period is 2**pwm_bits cycles
    localparam int pwm_bits = 8;

    // wheel duties
    localparam logic [7:0] duty_fast = 8'd200;
    localparam logic [7:0] duty_slow = 8'd60;

    // segment patterns, active low, bit 6 is segment g
    localparam logic [6:0] seg_table [16] = '{
        7'b1000000,
        7'b1111001,
        7'b0100100,
        7'b0110000,
        7'b0011001,
        7'b0010010,
        7'b0000010,
        7'b1111000,
        7'b0000000,
        7'b0010000,
        7'b0111111,
        7'b1111111,
        7'b1111111,
        7'b1111111,
        7'b1111111,
        7'b1111111
    };

endpackage

`default_nettype wire

// ==== hdl/sensor_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module sensor_sync #(
    parameter logic [15:0] debounce_cycles = car_pkg::debounce_cycles
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic left_track,
    input  wire logic mid_track,
    input  wire logic right_track,
    output logic      track_l,
    output logic      track_m,
    output logic      track_r
);

    logic [2:0]  sync_1;
    logic [2:0]  sync_2;
    logic [2:0]  held;
    logic [15:0] stable_cnt;

    // two-flop synchronizer, triple packed as {left, mid, right}
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1 <= 3'b000;
            sync_2 <= 3'b000;
        end else begin
            sync_1 <= {left_track, mid_track, right_track};
            sync_2 <= sync_1;
        end
    end

    // restart on a change still in flight or when nothing differs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stable_cnt <= 16'd0;
            held       <= 3'b000;
        end else if (sync_1 != sync_2 || sync_2 == held) begin
            stable_cnt <= 16'd0;
        end else if (stable_cnt == debounce_cycles - 16'd1) begin
            // debounce_cycles stable samples seen
            stable_cnt <= 16'd0;
            held       <= sync_2;
        end else begin
            stable_cnt <= stable_cnt + 16'd1;
        end
    end

    assign track_l = held[2];
    assign track_m = held[1];
    assign track_r = held[0];

    a_held_only_at_limit: assert property (
        @(posedge clk) disable iff (reset)
        (stable_cnt != debounce_cycles - 16'd1) |=> $stable(held)
    );

endmodule

`default_nettype wire

// ==== tracker/tracker_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracker_fsm #(
    parameter logic [29:0] long_dark_cycles = car_pkg::long_dark_cycles
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           start_move,
    input  wire logic           track_l,
    input  wire logic           track_m,
    input  wire logic           track_r,
    output car_pkg::drive_state_t state
);

    logic [2:0]            sensor;
    logic                  lap_ccw;
    logic [29:0]           dark_cnt;
    car_pkg::drive_state_t state_next;

    assign sensor = {track_l, track_m, track_r};

    // lap direction, set once when leaving the start mark on 011
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lap_ccw <= 1'b0;
        end else if (sensor == 3'b011 && state == car_pkg::stop) begin
            lap_ccw <= 1'b1;
        end
    end

    // length of the current all-dark run, saturating
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dark_cnt <= 30'd0;
        end else if (sensor != 3'b111) begin
            dark_cnt <= 30'd0;
        end else if (dark_cnt != {30{1'b1}}) begin
            dark_cnt <= dark_cnt + 30'd1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            car_pkg::stop: begin
                if (start_move && (sensor == 3'b110 || sensor == 3'b011)) begin
                    state_next = car_pkg::go_straight;
                end
            end
            car_pkg::go_straight: begin
                if (sensor == 3'b111 && dark_cnt <= long_dark_cycles) begin
                    state_next = car_pkg::go_straight;
                end else if (sensor == 3'b111) begin
                    // lost the line for too long, swing toward the inside
                    state_next = lap_ccw ? car_pkg::turn_left : car_pkg::turn_right;
                end else begin
                    state_next = lap_ccw ? car_pkg::turn_right : car_pkg::turn_left;
                end
            end
            car_pkg::turn_left: begin
                if (lap_ccw) begin
                    if (sensor != 3'b111) begin
                        state_next = car_pkg::go_straight;
                    end
                end else if (sensor == 3'b110) begin
                    state_next = car_pkg::go_straight;
                end
            end
            car_pkg::turn_right: begin
                if (lap_ccw) begin
                    if (sensor == 3'b011) begin
                        state_next = car_pkg::go_straight;
                    end
                end else if (sensor != 3'b111) begin
                    state_next = car_pkg::go_straight;
                end
            end
            default: state_next = car_pkg::stop;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= car_pkg::stop;
        end else begin
            state <= state_next;
        end
    end

    a_start_needs_move: assert property (
        @(posedge clk) disable iff (reset)
        (state == car_pkg::stop && !start_move) |=> (state == car_pkg::stop)
    );

endmodule

`default_nettype wire

// ==== hdl/motor_pwm.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_pwm (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire car_pkg::drive_state_t state,
    output logic                       motor_left_pwm,
    output logic                       motor_right_pwm
);

    localparam int period = 2 ** car_pkg::pwm_bits;

    logic [car_pkg::pwm_bits-1:0] pwm_cnt;
    logic [car_pkg::pwm_bits-1:0] duty_l;
    logic [car_pkg::pwm_bits-1:0] duty_r;
    logic                         wrap;

    assign wrap = (pwm_cnt == {car_pkg::pwm_bits{1'b1}});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // duties change only at the wrap, so a period is never cut short
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            duty_l <= '0;
            duty_r <= '0;
        end else if (wrap) begin
            case (state)
                car_pkg::go_straight: begin
                    duty_l <= car_pkg::duty_fast;
                    duty_r <= car_pkg::duty_fast;
                end
                car_pkg::turn_left: begin
                    duty_l <= car_pkg::duty_slow;
                    duty_r <= car_pkg::duty_fast;
                end
                car_pkg::turn_right: begin
                    duty_l <= car_pkg::duty_fast;
                    duty_r <= car_pkg::duty_slow;
                end
                default: begin
                    duty_l <= '0;
                    duty_r <= '0;
                end
            endcase
        end
    end

    assign motor_left_pwm  = (pwm_cnt < duty_l);
    assign motor_right_pwm = (pwm_cnt < duty_r);

    a_stop_period_quiet: assert property (
        @(posedge clk) disable iff (reset)
        (wrap && state == car_pkg::stop) |=> (!motor_left_pwm && !motor_right_pwm) [*period]
    );

endmodule

`default_nettype wire

// ==== display/seven_segment.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_segment #(
    parameter int scan_div_bits = car_pkg::scan_div_bits
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire car_pkg::drive_state_t state,
    input  wire logic                  track_l,
    input  wire logic                  track_m,
    input  wire logic                  track_r,
    output logic [6:0]                 segments,
    output logic [3:0]                 digit_sel
);

    logic [scan_div_bits-1:0] scan_div;
    logic                     scan_en;
    logic [3:0]               digit_val;

    // scan strobe, one cycle every 2**scan_div_bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_div <= '0;
        end else begin
            scan_div <= scan_div + 1'b1;
        end
    end

    assign scan_en = (scan_div == {scan_div_bits{1'b1}});

    // select and its value move together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            digit_sel <= 4'b1111;
            digit_val <= 4'd15;
        end else if (scan_en) begin
            case (digit_sel)
                4'b1110: begin
                    digit_sel <= 4'b1101;
                    digit_val <= {3'b000, track_m};
                end
                4'b1101: begin
                    digit_sel <= 4'b1011;
                    digit_val <= {3'b000, track_l};
                end
                4'b1011: begin
                    digit_sel <= 4'b0111;
                    digit_val <= {2'b00, state};
                end
                default: begin
                    // also the first step out of reset
                    digit_sel <= 4'b1110;
                    digit_val <= {3'b000, track_r};
                end
            endcase
        end
    end

    assign segments = car_pkg::seg_table[digit_val];

endmodule

`default_nettype wire

// ==== hdl/car_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module car_top #(
    parameter logic [29:0] long_dark_cycles = car_pkg::long_dark_cycles,
    parameter logic [15:0] debounce_cycles  = car_pkg::debounce_cycles,
    parameter int          scan_div_bits    = car_pkg::scan_div_bits
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             left_track,
    input  wire logic             mid_track,
    input  wire logic             right_track,
    input  wire logic             start_move,
    output car_pkg::drive_state_t state,
    output logic                  motor_left_pwm,
    output logic                  motor_right_pwm,
    output logic [6:0]            segments,
    output logic [3:0]            digit_sel
);

    // debounced sensor bits, 1 sees the line
    logic track_l;
    logic track_m;
    logic track_r;

    sensor_sync #(
        .debounce_cycles(debounce_cycles)
    ) sensor_sync_inst (
        .clk        (clk),
        .reset      (reset),
        .left_track (left_track),
        .mid_track  (mid_track),
        .right_track(right_track),
        .track_l    (track_l),
        .track_m    (track_m),
        .track_r    (track_r)
    );

    tracker_fsm #(
        .long_dark_cycles(long_dark_cycles)
    ) tracker_fsm_inst (
        .clk       (clk),
        .reset     (reset),
        .start_move(start_move),
        .track_l   (track_l),
        .track_m   (track_m),
        .track_r   (track_r),
        .state     (state)
    );

    motor_pwm motor_pwm_inst (
        .clk            (clk),
        .reset          (reset),
        .state          (state),
        .motor_left_pwm (motor_left_pwm),
        .motor_right_pwm(motor_right_pwm)
    );

    seven_segment #(
        .scan_div_bits(scan_div_bits)
    ) seven_segment_inst (
        .clk      (clk),
        .reset    (reset),
        .state    (state),
        .track_l  (track_l),
        .track_m  (track_m),
        .track_r  (track_r),
        .segments (segments),
        .digit_sel(digit_sel)
    );

endmodule

`default_nettype wire

// ==== verification/car_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module car_tb;

    localparam logic [15:0] deb = 16'd4;
    localparam logic [29:0] long_run = 30'd40;
    localparam int scan_bits = 3;
    localparam int pwm_period = 2 ** car_pkg::pwm_bits;
    localparam int settle_cycles = deb + 6;
    // measures and alignments dominate, then the dark runs and debounce waits
    localparam int cycle_limit = 14 * pwm_period + 30 * (long_run + settle_cycles) + 2000;

    logic clk;
    logic reset;
    logic left_track;
    logic mid_track;
    logic right_track;
    logic start_move;
    car_pkg::drive_state_t state;
    logic motor_left_pwm;
    logic motor_right_pwm;
    logic [6:0] segments;
    logic [3:0] digit_sel;

    int errors;
    int cycles;
    int since_reset;
    int seed;
    logic flag_model;

    car_top #(
        .long_dark_cycles(long_run),
        .debounce_cycles (deb),
        .scan_div_bits   (scan_bits)
    ) car_top_inst (
        .clk            (clk),
        .reset          (reset),
        .left_track     (left_track),
        .mid_track      (mid_track),
        .right_track    (right_track),
        .start_move     (start_move),
        .state          (state),
        .motor_left_pwm (motor_left_pwm),
        .motor_right_pwm(motor_right_pwm),
        .segments       (segments),
        .digit_sel      (digit_sel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // tracks the free-running pwm counter phase
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            since_reset <= 0;
        end else begin
            since_reset <= since_reset + 1;
        end
    end

    // transition rules of the tracking machine, triple is {left, mid, right}
    function automatic car_pkg::drive_state_t expected_next(car_pkg::drive_state_t cur,
            logic [2:0] triple, logic start, logic flag, logic long_dark);
        car_pkg::drive_state_t nxt;
        nxt = cur;
        if (cur == car_pkg::stop) begin
            if (start && (triple == 3'b110 || triple == 3'b011))
                nxt = car_pkg::go_straight;
        end else if (cur == car_pkg::go_straight) begin
            if (triple == 3'b111 && long_dark)
                nxt = flag ? car_pkg::turn_left : car_pkg::turn_right;
            else if (triple != 3'b111)
                nxt = flag ? car_pkg::turn_right : car_pkg::turn_left;
        end else if (cur == car_pkg::turn_left) begin
            if ((flag && triple != 3'b111) || (!flag && triple == 3'b110))
                nxt = car_pkg::go_straight;
        end else begin
            if ((flag && triple == 3'b011) || (!flag && triple != 3'b111))
                nxt = car_pkg::go_straight;
        end
        return nxt;
    endfunction

    task automatic drive_pins(input logic [2:0] triple);
        {left_track, mid_track, right_track} = triple;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        drive_pins(3'b000);
        start_move = 1'b0;
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        flag_model = 1'b0;
    endtask

    task automatic expect_state(input car_pkg::drive_state_t exp);
        assert (state == exp) else begin
            errors++;
            $display("[FAIL] %0t state expected %0d got %0d", $time, exp, state);
        end
    endtask

    task automatic hold_state(input car_pkg::drive_state_t exp, input int n);
        repeat (n) begin
            @(negedge clk);
            expect_state(exp);
        end
    endtask

    task automatic wait_for_state(input car_pkg::drive_state_t exp);
        int i;
        // debounced pins settle first, so a passing state is not taken for the result
        repeat (settle_cycles) @(negedge clk);
        for (i = 0; i < deb + long_run + 20; i++) begin
            @(negedge clk);
            if (state == exp) break;
        end
        assert (state == exp) else begin
            errors++;
            $display("%0t state never reached %0d, still at %0d", $time, exp, state);
        end
    endtask

    // start from stop with start_move high on the given triple
    task automatic start_from(input logic [2:0] triple);
        apply_reset();
        drive_pins(triple);
        start_move = 1'b1;
        flag_model = (triple == 3'b011);
        wait_for_state(expected_next(car_pkg::stop, triple, 1'b1, flag_model, 1'b0));
    endtask

    // counts high cycles over the period after the next counter wrap
    task automatic measure_period(input logic [7:0] exp_l, input logic [7:0] exp_r);
        int high_l;
        int high_r;
        high_l = 0;
        high_r = 0;
        do @(negedge clk); while (since_reset % pwm_period != pwm_period - 1);
        repeat (pwm_period) begin
            @(negedge clk);
            high_l += motor_left_pwm;
            high_r += motor_right_pwm;
        end
        assert (high_l == exp_l) else begin
            errors++;
            $display("[FAIL] %0t motor_left_pwm expected %0d got %0d", $time, exp_l, high_l);
        end
        assert (high_r == exp_r) else begin
            errors++;
            $display("[FAIL] %0t motor_right_pwm expected %0d got %0d", $time, exp_r, high_r);
        end
    endtask

    task automatic check_reset_values();
        apply_reset();
        expect_state(car_pkg::stop);
        @(negedge clk);
        assert (digit_sel == 4'b1111) else begin
            errors++;
            $display("[FAIL] %0t digit_sel expected 1111 got %b", $time, digit_sel);
        end
        measure_period(8'd0, 8'd0);
    endtask

    task automatic check_start_gate();
        apply_reset();
        drive_pins(3'b110);
        hold_state(car_pkg::stop, settle_cycles + 10);
        drive_pins(3'b011);
        hold_state(car_pkg::stop, settle_cycles + 10);
        start_from(3'b110);
    endtask

    task automatic check_turn(input logic [2:0] start_triple);
        car_pkg::drive_state_t turn;
        start_from(start_triple);
        turn = expected_next(car_pkg::go_straight, 3'b010, 1'b1, flag_model, 1'b0);
        @(negedge clk);
        drive_pins(3'b010);
        wait_for_state(turn);
        hold_state(turn, 10);
        drive_pins(start_triple);
        wait_for_state(expected_next(turn, start_triple, 1'b1, flag_model, 1'b0));
    endtask

    // enter 111 so the debounced change lands on a go_straight cycle
    task automatic enter_dark(input logic [2:0] start_triple);
        car_pkg::drive_state_t target;
        target = car_pkg::go_straight;
        if ((deb + 2) % 2 != 0)
            target = expected_next(car_pkg::go_straight, start_triple, 1'b1, flag_model, 1'b0);
        do @(negedge clk); while (state != target);
        drive_pins(3'b111);
    endtask

    task automatic check_dark_run(input logic [2:0] start_triple);
        car_pkg::drive_state_t turn;
        start_from(start_triple);
        enter_dark(start_triple);
        repeat (deb + 2) @(negedge clk);
        hold_state(car_pkg::go_straight, long_run);
        turn = expected_next(car_pkg::go_straight, 3'b111, 1'b1, flag_model, 1'b1);
        wait_for_state(turn);
        hold_state(turn, 10);
    endtask

    // glitches on a held dark turn, where any accepted change would end the turn
    task automatic check_glitches();
        int g;
        int len;
        int rnd;
        logic [2:0] mask;
        car_pkg::drive_state_t turn;
        start_from(3'b011);
        enter_dark(3'b011);
        turn = expected_next(car_pkg::go_straight, 3'b111, 1'b1, flag_model, 1'b1);
        wait_for_state(turn);
        for (g = 0; g < 12; g++) begin
            rnd = $random(seed);
            mask = rnd[2:0];
            if (mask == 3'b000) mask = 3'b001;
            len = 1 + ({$random(seed)} % (deb - 1));
            drive_pins(3'b111 ^ mask);
            hold_state(turn, len);
            drive_pins(3'b111);
            hold_state(turn, deb + 3);
        end
    endtask

    task automatic check_pwm_duties();
        start_from(3'b110);
        drive_pins(3'b010);
        wait_for_state(car_pkg::turn_left);
        measure_period(car_pkg::duty_slow, car_pkg::duty_fast);
        start_from(3'b011);
        drive_pins(3'b010);
        wait_for_state(car_pkg::turn_right);
        measure_period(car_pkg::duty_fast, car_pkg::duty_slow);
        // straight only holds during a short dark run, so a wrap must fall inside it
        start_from(3'b110);
        do @(negedge clk);
        while (!(since_reset % pwm_period >= 224 && since_reset % pwm_period <= 230
                 && state == car_pkg::go_straight));
        drive_pins(3'b111);
        measure_period(car_pkg::duty_fast, car_pkg::duty_fast);
    endtask

    // scans the display while a turn holds on run_triple
    task automatic check_display(input logic [2:0] start_triple, input logic [2:0] run_triple);
        int i;
        int val;
        logic [3:0] seen;
        car_pkg::drive_state_t turn;
        seen = 4'b0000;
        start_from(start_triple);
        turn = expected_next(car_pkg::go_straight, run_triple, 1'b1, flag_model, 1'b0);
        drive_pins(run_triple);
        wait_for_state(turn);
        repeat (settle_cycles) @(negedge clk);
        for (i = 0; i < 10 * (2 ** scan_bits); i++) begin
            @(negedge clk);
            case (digit_sel)
                4'b1110: begin
                    val = run_triple[0];
                    seen[0] = 1'b1;
                end
                4'b1101: begin
                    val = run_triple[1];
                    seen[1] = 1'b1;
                end
                4'b1011: begin
                    val = run_triple[2];
                    seen[2] = 1'b1;
                end
                default: begin
                    val = turn;
                    seen[3] = 1'b1;
                end
            endcase
            assert (segments == car_pkg::seg_table[val]) else begin
                errors++;
                $display("[FAIL] %0t segments expected %b got %b", $time,
                         car_pkg::seg_table[val], segments);
            end
        end
        assert (seen == 4'b1111) else begin
            errors++;
            $display("%0t display scan did not reach every digit", $time);
        end
    endtask

    initial begin
        errors = 0;
        cycles = 0;
        seed = 32'hfdf3;
        flag_model = 1'b0;
        reset = 1'b1;
        start_move = 1'b0;
        left_track = 1'b0;
        mid_track = 1'b0;
        right_track = 1'b0;
        check_reset_values();
        check_start_gate();
        check_turn(3'b110);
        check_turn(3'b011);
        check_dark_run(3'b110);
        check_dark_run(3'b011);
        check_glitches();
        check_pwm_duties();
        check_display(3'b110, 3'b010);
        check_display(3'b011, 3'b100);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/car_pkg.sv
hdl/sensor_sync.sv
tracker/tracker_fsm.sv
hdl/motor_pwm.sv
display/seven_segment.sv
hdl/car_top.sv
verification/car_tb.sv
